// File: verilog/mipsConsts.svh
/* core-wide widths and byte strobe patterns
   strobes are lane masks for word addressed stores, address bits 1:0 are not decoded */
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// data path and address width
`define DATA_W 32

// register file address width, 32 registers
`define REG_BITS 5

// pc advance per instruction
`define PC_STEP 4

// store byte lanes
`define STRB_WORD 4'b1111
`define STRB_HALF 4'b0011
`define STRB_BYTE 4'b0001

`endif

// File: verilog/isaPkg.sv
/* kept MIPS subset only; opcodes follow the legacy core's map, which is not standard MIPS
   (lw is 100000), so programs must be assembled for it */
`default_nettype none
`include "mipsConsts.svh"

package isaPkg;

   typedef enum logic [5:0] {
      opRtype = 6'b000000,
      opJ     = 6'b000010,
      opBeq   = 6'b000100,
      opBne   = 6'b000101,
      opAddi  = 6'b001000,
      opAndi  = 6'b001100,
      opLw    = 6'b100000,
      opSb    = 6'b101000,
      opSh    = 6'b101001
   } opcodeT;

   typedef enum logic [5:0] {
      fnAdd = 6'b100000,
      fnSub = 6'b100010,
      fnOr  = 6'b100101
   } functT;

   typedef struct packed {
      opcodeT               op;
      logic [`REG_BITS-1:0] rs;
      logic [`REG_BITS-1:0] rt;
      logic [`REG_BITS-1:0] rd;
      logic [4:0]           shamt;   // no shifts here, kept for field layout
      functT                funct;
   } rTypeS;

   typedef struct packed {
      opcodeT               op;
      logic [`REG_BITS-1:0] rs;
      logic [`REG_BITS-1:0] rt;
      logic [15:0]          imm;
   } iTypeS;

   // same instruction word seen both ways
   typedef union packed {
      rTypeS r;
      iTypeS i;
   } instrU;

   typedef enum logic [2:0] {
      aluAnd = 3'b000,
      aluAdd = 3'b010,
      aluOr  = 3'b100,
      aluSub = 3'b110
   } aluOpT;

endpackage

`default_nettype wire

// File: verilog/corePkg.sv
/* multicycle core internals: controller states, datapath controls, memory request */
`default_nettype none

package corePkg;

   typedef enum logic [4:0] {
      fetch, decode, memAdr, lwRd, lwWr, sbWr, shWr,
      rtypeEx, rtypeWr, bex, beqEx, bneEx,
      andiEx, andiWr, addiEx, addiWr, jEx
   } stateT;

   typedef struct packed {
      logic           srcA;       // 0 pc, 1 register A
      logic [1:0]     srcB;       // B, 4, imm, branch offset
      isaPkg::aluOpT  aluOp;
      logic [1:0]     pcSrc;      // alu, aluOut, jump target
      logic           pcEn;
      logic           irWrite;
      logic           regWrite;
      logic           regDstRd;   // rd instead of rt
      logic           memToReg;
   } ctrlS;

   typedef struct packed {
      logic       valid;
      logic       write;
      logic       useAluOut;   // address from aluOut, else pc
      logic [3:0] strb;
   } memReqS;

endpackage

`default_nettype wire

// File: verilog/mainControl.sv
/* one instruction at a time; memory states hold their request until memDone
   unknown opcodes fall back to fetch without side effects */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module mainControl (
   input  logic             clk,
   input  logic             reset,
   input  isaPkg::instrU    instr,
   input  logic             zero,
   input  logic             memDone,
   output corePkg::ctrlS    ctrl,
   output corePkg::memReqS  memReq
);
   import isaPkg::*;
   import corePkg::*;

   stateT state;
   stateT nextState;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= fetch;
      else
         state <= nextState;
   end

   // ------------------------------------------------------------
   // next state and control outputs
   // ------------------------------------------------------------
   always_comb
   begin
      ctrl = '0;
      ctrl.aluOp = aluAdd;
      memReq = '0;
      nextState = fetch;
      case (state)
         fetch:
         begin
            memReq.valid = 1'b1;
            memReq.strb = `STRB_WORD;
            ctrl.srcB = 2'd1;       // pc + 4
            ctrl.irWrite = 1'b1;
            ctrl.pcEn = memDone;
            nextState = memDone ? decode : fetch;
         end
         decode:
         begin
            case (instr.i.op)
               opLw, opSb, opSh: nextState = memAdr;
               opRtype:          nextState = rtypeEx;
               opBeq, opBne:     nextState = bex;
               opAndi:           nextState = andiEx;
               opAddi:           nextState = addiEx;
               opJ:              nextState = jEx;
               default:          nextState = fetch;
            endcase
         end
         memAdr:
         begin
            ctrl.srcA = 1'b1;
            ctrl.srcB = 2'd2;
            case (instr.i.op)
               opLw:    nextState = lwRd;
               opSb:    nextState = sbWr;
               opSh:    nextState = shWr;
               default: nextState = fetch;
            endcase
         end
         lwRd, sbWr, shWr:
         begin
            // keep recomputing the address so aluOut holds during wait states
            ctrl.srcA = 1'b1;
            ctrl.srcB = 2'd2;
            memReq.valid = 1'b1;
            memReq.useAluOut = 1'b1;
            memReq.write = (state != lwRd);
            memReq.strb = (state == sbWr) ? `STRB_BYTE :
                          (state == shWr) ? `STRB_HALF : `STRB_WORD;
            if (memDone)
               nextState = (state == lwRd) ? lwWr : fetch;
            else
               nextState = state;
         end
         lwWr:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
         end
         rtypeEx:
         begin
            ctrl.srcA = 1'b1;
            nextState = rtypeWr;
            case (instr.r.funct)
               fnSub:   ctrl.aluOp = aluSub;
               fnOr:    ctrl.aluOp = aluOr;
               default: ctrl.aluOp = aluAdd;
            endcase
         end
         rtypeWr:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDstRd = 1'b1;
         end
         bex:
         begin
            ctrl.srcB = 2'd3;
            nextState = (instr.i.op == opBne) ? bneEx : beqEx;
         end
         beqEx, bneEx:
         begin
            ctrl.srcA = 1'b1;
            ctrl.aluOp = aluSub;    // zero flag compares A and B
            ctrl.pcSrc = 2'd1;
            ctrl.pcEn = (state == beqEx) ? zero : !zero;
         end
         andiEx, addiEx:
         begin
            ctrl.srcA = 1'b1;
            ctrl.srcB = 2'd2;
            ctrl.aluOp = (state == andiEx) ? aluAnd : aluAdd;
            nextState = (state == andiEx) ? andiWr : addiWr;
         end
         andiWr, addiWr: ctrl.regWrite = 1'b1;
         jEx:
         begin
            ctrl.pcSrc = 2'd2;
            ctrl.pcEn = 1'b1;
         end
         default: nextState = fetch;
      endcase
   end

   // a request is never dropped before the bridge finishes it
   assert property (@(posedge clk) disable iff (reset)
      memReq.valid && !memDone |=> memReq.valid);
   // completions only arrive while a request is pending
   assert property (@(posedge clk) disable iff (reset) memDone |-> memReq.valid);
   assert property (@(posedge clk) disable iff (reset) !$isunknown(state) && state <= jEx);

endmodule

`default_nettype wire

// File: verilog/dataPath.sv
/* register file clears on reset and ignores writes to r0
   A, B, aluOut and the memory data register load every cycle */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module dataPath (
   input  logic                clk,
   input  logic                reset,
   input  corePkg::ctrlS       ctrl,
   input  logic [`DATA_W-1:0]  memData,
   input  logic                memDone,
   output isaPkg::instrU       instr,
   output logic                zero,
   output logic [`DATA_W-1:0]  pc,
   output logic [`DATA_W-1:0]  aluOut,
   output logic [`DATA_W-1:0]  storeData
);
   import isaPkg::*;

   logic [`DATA_W-1:0]  regFile [0:(1<<`REG_BITS)-1];
   logic [`DATA_W-1:0]  rd1;
   logic [`DATA_W-1:0]  rd2;
   logic [`DATA_W-1:0]  aReg;
   logic [`DATA_W-1:0]  mdr;
   logic [`DATA_W-1:0]  srcA;
   logic [`DATA_W-1:0]  srcB;
   logic [`DATA_W-1:0]  aluRes;
   logic [`DATA_W-1:0]  nextPc;
   logic [`DATA_W-1:0]  immExt;
   logic [`DATA_W-1:0]  brOff;
   logic [`DATA_W-1:0]  jumpTarget;
   logic [`DATA_W-1:0]  wrData;
   logic [`REG_BITS-1:0] wrAddr;

   // ------------------------------------------------------------
   // state registers
   // ------------------------------------------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (ctrl.pcEn)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (ctrl.irWrite && memDone)
         instr <= memData;
      mdr <= memData;
      aReg <= rd1;
      storeData <= rd2;         // B register
      aluOut <= aluRes;
   end

   // register file, r0 hardwired
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int k = 0; k < (1<<`REG_BITS); k++)
            regFile[k] <= '0;
      end
      else if (ctrl.regWrite && wrAddr != '0)
         regFile[wrAddr] <= wrData;
   end

   assign rd1 = regFile[instr.r.rs];
   assign rd2 = regFile[instr.r.rt];
   assign wrAddr = ctrl.regDstRd ? instr.r.rd : instr.r.rt;
   assign wrData = ctrl.memToReg ? mdr : aluOut;

   // ------------------------------------------------------------
   // operand selection and ALU
   // ------------------------------------------------------------
   assign immExt = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm};
   assign brOff = {immExt[`DATA_W-3:0], 2'b00};
   assign jumpTarget = {pc[`DATA_W-1:28], instr[25:0], 2'b00};   // pc already advanced

   assign srcA = ctrl.srcA ? aReg : pc;

   always_comb
   begin
      case (ctrl.srcB)
         2'd0:    srcB = storeData;
         2'd1:    srcB = `PC_STEP;
         2'd2:    srcB = immExt;
         default: srcB = brOff;
      endcase
      case (ctrl.aluOp)
         aluSub:  aluRes = srcA - srcB;
         aluAnd:  aluRes = srcA & srcB;
         aluOr:   aluRes = srcA | srcB;
         default: aluRes = srcA + srcB;
      endcase
      case (ctrl.pcSrc)
         2'd1:    nextPc = aluOut;
         2'd2:    nextPc = jumpTarget;
         default: nextPc = aluRes;
      endcase
   end

   assign zero = (aluRes == '0);

   // a zero source register always shows up as zero in the operand registers
   assert property (@(posedge clk) disable iff (reset) instr.r.rs == '0 |=> aReg == '0);
   assert property (@(posedge clk) disable iff (reset) instr.r.rt == '0 |=> storeData == '0);

endmodule

`default_nettype wire

// File: verilog/apbBridge.sv
/* one APB transfer per request, no pipelining; memDone pulses one cycle after completion
   paddr is word aligned, read strobes are driven as zero */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module apbBridge (
   input  logic                clk,
   input  logic                reset,
   input  corePkg::memReqS     memReq,
   input  logic [`DATA_W-1:0]  pc,
   input  logic [`DATA_W-1:0]  aluOut,
   input  logic [`DATA_W-1:0]  storeData,
   output logic                memDone,
   output logic [`DATA_W-1:0]  memData,
   output logic                psel,
   output logic                penable,
   output logic                pwrite,
   output logic [`DATA_W-1:0]  paddr,
   output logic [`DATA_W-1:0]  pwdata,
   output logic [3:0]          pstrb,
   input  logic [`DATA_W-1:0]  prdata,
   input  logic                pready
);
   typedef enum logic [1:0] {phIdle, phSetup, phAccess} phaseT;

   phaseT phase;
   logic  start;
   logic  [`DATA_W-1:0] addr;

   // held request must not restart while memDone is still high
   assign start = (phase == phIdle) && memReq.valid && !memDone;
   assign addr = memReq.useAluOut ? aluOut : pc;
   assign psel = (phase != phIdle);
   assign penable = (phase == phAccess);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         phase <= phIdle;
         memDone <= 1'b0;
      end
      else
      begin
         memDone <= 1'b0;
         case (phase)
            phIdle:   if (start) phase <= phSetup;
            phSetup:  phase <= phAccess;
            phAccess:
            begin
               if (pready)
               begin
                  phase <= phIdle;
                  memDone <= 1'b1;
               end
            end
            default:  phase <= phIdle;
         endcase
      end
   end

   // transfer payload, captured once per request
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         paddr <= {addr[`DATA_W-1:2], 2'b00};
         pwrite <= memReq.write;
         pwdata <= storeData;
         pstrb <= memReq.write ? memReq.strb : 4'b0000;
      end
      if (penable && pready)
         memData <= prdata;
   end

   // access phase always follows a setup phase
   assert property (@(posedge clk) disable iff (reset) penable |-> psel && $past(psel));

endmodule

`default_nettype wire

// File: verilog/mipsTop.sv
/* multicycle MIPS subset core with a single APB requester port
   instruction and data share one address space */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module mipsTop (
   input  logic                clk,
   input  logic                reset,
   output logic                psel,
   output logic                penable,
   output logic                pwrite,
   output logic [`DATA_W-1:0]  paddr,
   output logic [`DATA_W-1:0]  pwdata,
   output logic [3:0]          pstrb,
   input  logic [`DATA_W-1:0]  prdata,
   input  logic                pready
);
   import isaPkg::*;
   import corePkg::*;

   ctrlS                ctrl;
   memReqS              memReq;
   instrU               instr;
   logic                zero;
   logic                memDone;
   logic [`DATA_W-1:0]  memData;
   logic [`DATA_W-1:0]  pc;
   logic [`DATA_W-1:0]  aluOut;
   logic [`DATA_W-1:0]  storeData;

   mainControl ctrl0 (
      .clk(clk), .reset(reset), .instr(instr), .zero(zero),
      .memDone(memDone), .ctrl(ctrl), .memReq(memReq)
   );

   dataPath dp0 (
      .clk(clk), .reset(reset), .ctrl(ctrl), .memData(memData), .memDone(memDone),
      .instr(instr), .zero(zero), .pc(pc), .aluOut(aluOut), .storeData(storeData)
   );

   apbBridge bridge0 (
      .clk(clk), .reset(reset), .memReq(memReq), .pc(pc), .aluOut(aluOut),
      .storeData(storeData), .memDone(memDone), .memData(memData),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
      .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
   );

endmodule

`default_nettype wire

// File: verif/apbMem.sv
/* APB memory model, 256 words, 0 to 3 wait states per transfer from an xorshift draw
   reset reloads the test program; stores honor pstrb, address bits 1:0 are ignored */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module apbMem #(
   parameter logic [15:0]        valA = 16'd100,
   parameter logic [15:0]        valB = 16'd37,
   parameter logic [15:0]        maskC = 16'h2C,
   parameter logic [15:0]        marker = 16'hBAD,
   parameter logic [15:0]        loadOff = 16'h11,
   parameter logic [`DATA_W-1:0] loadWord = 32'h12345678
) (
   input  logic                clk,
   input  logic                reset,
   input  logic                psel,
   input  logic                penable,
   input  logic                pwrite,
   input  logic [`DATA_W-1:0]  paddr,
   input  logic [`DATA_W-1:0]  pwdata,
   input  logic [3:0]          pstrb,
   output logic [`DATA_W-1:0]  prdata,
   output logic                pready,
   output int                  writeCount
);
   import isaPkg::*;

   logic [`DATA_W-1:0] mem [0:255];
   logic [`DATA_W-1:0] rdataReg = '0;
   logic               readyReg = 1'b0;
   logic [31:0]        rng;
   logic [1:0]         waitLeft;

   assign prdata = rdataReg;
   assign pready = readyReg;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] iInstr(input opcodeT op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] rInstr(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input functT fn);
      return {opRtype, rs, rt, rd, 5'd0, fn};
   endfunction

   // ------------------------------------------------------------
   // test program, one word per index, byte address is 4 * k
   // ------------------------------------------------------------
   function automatic logic [31:0] initWord(input int k);
      case (k)
         0:  return iInstr(opAddi, 5'd0, 5'd1, valA);
         1:  return iInstr(opAddi, 5'd0, 5'd2, valB);
         2:  return iInstr(opAddi, 5'd0, 5'd9, marker);   // r9 holds the marker
         3:  return rInstr(5'd1, 5'd2, 5'd3, fnAdd);
         4:  return rInstr(5'd1, 5'd2, 5'd4, fnSub);
         5:  return rInstr(5'd1, 5'd2, 5'd5, fnOr);
         6:  return iInstr(opAndi, 5'd1, 5'd6, maskC);
         7:  return iInstr(opSh, 5'd0, 5'd3, 16'h0100);
         8:  return iInstr(opSh, 5'd0, 5'd4, 16'h0104);
         9:  return iInstr(opSh, 5'd0, 5'd5, 16'h0108);
         10: return iInstr(opSb, 5'd0, 5'd6, 16'h010C);
         11: return iInstr(opLw, 5'd0, 5'd7, 16'h0200);
         12: return iInstr(opAddi, 5'd7, 5'd8, loadOff);
         13: return iInstr(opSh, 5'd0, 5'd8, 16'h0110);
         14: return iInstr(opBeq, 5'd1, 5'd1, 16'd1);      // taken
         15: return iInstr(opSb, 5'd0, 5'd9, 16'h0114);   // skipped slot
         16: return iInstr(opSh, 5'd0, 5'd1, 16'h0118);
         17: return iInstr(opBeq, 5'd1, 5'd2, 16'd1);      // falls through
         18: return iInstr(opSh, 5'd0, 5'd2, 16'h011C);
         19: return iInstr(opBne, 5'd1, 5'd2, 16'd1);      // taken
         20: return iInstr(opSb, 5'd0, 5'd9, 16'h0120);   // skipped slot
         21: return iInstr(opSh, 5'd0, 5'd5, 16'h0124);
         22: return iInstr(opBne, 5'd1, 5'd1, 16'd1);      // falls through
         23: return iInstr(opSb, 5'd0, 5'd6, 16'h0128);
         24: return {opJ, 26'd24};                        // parks on itself
         128: return loadWord;                            // byte address 0x200
         default: return {24'hF1F1F1, k[7:0]};
      endcase
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         for (int k = 0; k < 256; k++)
            mem[k] <= initWord(k);
         rng <= 32'd93170;
         readyReg <= 1'b0;
         waitLeft <= 2'd0;
         rdataReg <= '0;
         writeCount <= 0;
      end
      else if (psel && !penable)
      begin
         // setup cycle, draw the wait count
         rng <= xorshift(rng);
         waitLeft <= rng[1:0];
         readyReg <= (rng[1:0] == 2'd0);
         rdataReg <= mem[paddr[9:2]];
      end
      else if (psel && penable && !readyReg)
      begin
         waitLeft <= waitLeft - 2'd1;
         readyReg <= (waitLeft == 2'd1);
      end
      else if (psel && penable)
      begin
         readyReg <= 1'b0;
         if (pwrite)
         begin
            writeCount <= writeCount + 1;
            for (int b = 0; b < 4; b++)
               if (pstrb[b])
                  mem[paddr[9:2]][8*b +: 8] <= pwdata[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// File: verif/tbMips.sv
/* testbench for mipsTop on the wait-stated APB memory
   expected stores mirror the program held in apbMem, checking is by concurrent assertions */
`timescale 1ns/1ps
`default_nettype none
`include "mipsConsts.svh"

module tbMips;

   typedef struct packed {
      logic [`DATA_W-1:0] addr;
      logic [`DATA_W-1:0] data;
      logic [3:0]         strb;
   } wrRecS;

   localparam logic [`DATA_W-1:0] valA = 32'd100;
   localparam logic [`DATA_W-1:0] valB = 32'd37;
   localparam logic [`DATA_W-1:0] maskC = 32'h2C;
   localparam logic [`DATA_W-1:0] marker = 32'hBAD;
   localparam logic [`DATA_W-1:0] loadWord = 32'h12345678;
   localparam logic [`DATA_W-1:0] loadOff = 32'h11;
   localparam logic [`DATA_W-1:0] jAddr = 32'h60;   // final j
   localparam int storeCount = 9;
   // 40 instructions, 5 states each, 5 cycles per state, plus margin
   localparam int maxCycles = 40 * 5 * 5 + 2000;

   logic               clk = 1'b0;
   logic               reset = 1'b1;
   logic               psel;
   logic               penable;
   logic               pwrite;
   logic               pready;
   logic [`DATA_W-1:0] paddr;
   logic [`DATA_W-1:0] pwdata;
   logic [`DATA_W-1:0] prdata;
   logic [3:0]         pstrb;
   int                 writeCount;
   int                 cycles = 0;
   int                 tailFetches = 0;
   int                 valueErrs = 0;
   int                 otherErrs = 0;
   int                 timedOut = 0;
   logic               seenXfer = 1'b0;
   logic               wrDone;
   wrRecS              expRec;
   logic [`DATA_W-1:0] lastAddr;
   logic [`DATA_W-1:0] lastData;
   logic [4:0]         lastCtrl;

   always #10 clk = ~clk;

   mipsTop dut0 (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready)
   );

   apbMem #(
      .valA(valA[15:0]), .valB(valB[15:0]), .maskC(maskC[15:0]), .marker(marker[15:0]),
      .loadOff(loadOff[15:0]), .loadWord(loadWord)
   ) mem0 (
      .clk(clk), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
      .writeCount(writeCount)
   );

   // stores in program order
   function automatic wrRecS expWrite(input int idx);
      case (idx)
         0: return {32'h100, valA + valB, `STRB_HALF};
         1: return {32'h104, valA - valB, `STRB_HALF};
         2: return {32'h108, valA | valB, `STRB_HALF};
         3: return {32'h10C, valA & maskC, `STRB_BYTE};
         4: return {32'h110, loadWord + loadOff, `STRB_HALF};
         5: return {32'h118, valA, `STRB_HALF};
         6: return {32'h11C, valB, `STRB_HALF};
         7: return {32'h124, valA | valB, `STRB_HALF};
         default: return {32'h128, valA & maskC, `STRB_BYTE};
      endcase
   endfunction

   function automatic string writeName(input int idx);
      case (idx)
         0: return "shAdd";
         1: return "shSub";
         2: return "shOr";
         3: return "sbAnd";
         4: return "loadRoundTrip";
         5: return "beqTakenTarget";
         6: return "beqFallThrough";
         7: return "bneTakenTarget";
         default: return "bneFallThrough";
      endcase
   endfunction

   task automatic reportErr(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
      valueErrs++;
      $display("ERR %s expected 0x%08h actual 0x%08h", name, expVal, actVal);
   endtask

   task automatic reportFail(input string what);
      otherErrs++;
      $display("failure: %s", what);
   endtask

   assign wrDone = psel && penable && pready && pwrite;
   assign expRec = expWrite(writeCount);

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      lastAddr <= paddr;
      lastData <= pwdata;
      lastCtrl <= {pwrite, pstrb};
      if (psel && !reset)
         seenXfer <= 1'b1;
      if (psel && !penable && writeCount == storeCount)
         tailFetches <= tailFetches + 1;
   end

   // ------------------------------------------------------------
   // reset and APB protocol
   // ------------------------------------------------------------
   assert property (@(posedge clk) $fell(reset) |-> !psel && !penable)
      else reportFail("psel or penable was high when reset was released");
   assert property (@(posedge clk) disable iff (reset) psel && !seenXfer |-> !pwrite && paddr == 0)
      else reportErr("firstFetch", 32'h0, $sampled(paddr));
   assert property (@(posedge clk) disable iff (reset) $rose(penable) |-> $past(psel))
      else reportFail("penable rose without a setup cycle before it");
   assert property (@(posedge clk) disable iff (reset) psel && !penable |=> penable)
      else reportFail("setup cycle was not followed by an access cycle");
   assert property (@(posedge clk) disable iff (reset) penable && pready |=> !psel && !penable)
      else reportFail("psel or penable stayed high after a completed transfer");
   assert property (@(posedge clk) disable iff (reset)
      psel && !(penable && pready) |=> $stable(paddr))
      else reportErr("holdAddr", $sampled(lastAddr), $sampled(paddr));
   assert property (@(posedge clk) disable iff (reset)
      psel && !(penable && pready) |=> $stable(pwdata))
      else reportErr("holdWdata", $sampled(lastData), $sampled(pwdata));
   assert property (@(posedge clk) disable iff (reset)
      psel && !(penable && pready) |=> $stable({pwrite, pstrb}))
      else reportErr("holdCtrl", 32'($sampled(lastCtrl)), 32'($sampled({pwrite, pstrb})));

   // ------------------------------------------------------------
   // stores, branches and the final loop
   // ------------------------------------------------------------
   assert property (@(posedge clk) disable iff (reset) wrDone |-> writeCount < storeCount)
      else reportFail("a store beyond the program's store count was issued");
   assert property (@(posedge clk) disable iff (reset) wrDone |-> pwdata != marker)
      else reportFail("the marker of a skipped branch slot was stored");
   assert property (@(posedge clk) disable iff (reset)
      wrDone && writeCount < storeCount |-> paddr == expRec.addr)
      else reportErr(writeName($sampled(writeCount)), $sampled(expRec.addr), $sampled(paddr));
   assert property (@(posedge clk) disable iff (reset)
      wrDone && writeCount < storeCount |-> pwdata == expRec.data)
      else reportErr(writeName($sampled(writeCount)), $sampled(expRec.data), $sampled(pwdata));
   assert property (@(posedge clk) disable iff (reset)
      wrDone && writeCount < storeCount |-> pstrb == expRec.strb)
      else reportErr(writeName($sampled(writeCount)), 32'($sampled(expRec.strb)),
                     32'($sampled(pstrb)));
   assert property (@(posedge clk) disable iff (reset)
      psel && !penable && writeCount == storeCount |-> !pwrite && paddr == jAddr)
      else reportErr("tailFetch", jAddr, $sampled(paddr));

   initial
   begin
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      while (cycles < maxCycles && !(writeCount == storeCount && tailFetches >= 6))
         @(posedge clk);
      if (cycles >= maxCycles)
         timedOut = 1;
      @(negedge clk);   // checks of the last edge report first
      if (timedOut != 0)
         $display("timeout: the program did not finish within %0d cycles", maxCycles);
      $display("value errors %0d, other failures %0d, stores %0d of %0d, cycles %0d",
               valueErrs, otherErrs + timedOut, writeCount, storeCount, cycles);
      if (valueErrs == 0 && otherErrs == 0 && timedOut == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
verilog/isaPkg.sv
verilog/corePkg.sv
verilog/mainControl.sv
verilog/dataPath.sv
verilog/apbBridge.sv
verilog/mipsTop.sv
verif/apbMem.sv
verif/tbMips.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, status follows the result line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tbMips -o simv

out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "TEST RESULT: PASS"
